/* stream_fifo.f */
hw/stream_fifo_pkg.sv
hw/sample_packer.sv
hw/bulk_store.sv
hw/transfer_engine.sv
hw/word_unpacker.sv
hw/fill_monitor.sv
hw/stream_fifo.sv
verif/stream_fifo_asserts.sv
verif/stream_fifo_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := stream_fifo_tb
FILELIST   := stream_fifo.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/100ps
RUN_FLAGS  := +verilator+error+limit+100

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

.PHONY: all build run lint clean

/* verif/stream_fifo_tb.sv */
`default_nettype none

module stream_fifo_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import stream_fifo_pkg::*;

	localparam int ORDER_SAMPLES = 64;
	localparam int PARTIAL_SAMPLES = 6;
	localparam int BULK_SAMPLES = 300;
	// Up to two write cycles and one and a half read cycles per sample, plus settling
	localparam int TEST_CYCLES = 4 * (ORDER_SAMPLES + PARTIAL_SAMPLES + BULK_SAMPLES) + 200;

	logic        ti_clk = 1'b0;
	logic        rst;
	logic        write_en;
	sample_t     data_in;
	logic        read_en;
	host_word_t  data_out;
	level_t      level;

	// Reference model
	sample_t     expect_q[$];
	int unsigned written = 0;
	int unsigned words_read = 0;
	host_word_t  last_word = '0;
	logic [15:0] lfsr = 16'd64;
	int          errors = 0;

	// Previous-cycle values for the monitor
	int          since_reset = 0;
	logic        read_prev = 1'b0;
	logic [1:0]  write_hist = '0;
	host_word_t  data_prev = '0;
	level_t      level_prev = '0;

	stream_fifo UUT (
		.ti_clk  (ti_clk),
		.rst     (rst),
		.write_en(write_en),
		.data_in (data_in),
		.read_en (read_en),
		.data_out(data_out),
		.level   (level)
	);

	always #2 ti_clk = ~ti_clk;

	////////////////////
	// Helpers
	////////////////////

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] random_bits(input int n);
		logic [15:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return bits;
	endfunction

	// Host words that whole chunks have made readable
	function automatic int words_ready();
		return (written / SAMPLES_PER_CHUNK) * 2 - words_read;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got == exp) else begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic next_cycle();
		@(posedge ti_clk);
		#1;
	endtask

	task automatic write_samples(input int n);
		sample_t s;
		for (int i = 0; i < n; i++) begin
			s = random_bits(16);
			write_en = 1'b1;
			data_in = s;
			expect_q.push_back(s);
			written++;
			next_cycle();
			write_en = 1'b0;
			if (random_bits(1) != 16'd0)
				next_cycle();
		end
	endtask

	task automatic read_words(input int n);
		host_word_t exp;
		sample_t    lo;
		sample_t    hi;
		for (int i = 0; i < n; i++) begin
			read_en = 1'b1;
			next_cycle();
			read_en = 1'b0;
			if (words_ready() > 0) begin
				lo = expect_q.pop_front();
				hi = expect_q.pop_front();
				exp = {hi, lo};
				words_read++;
			end else begin
				exp = last_word;
			end
			check_value("data_out", exp, data_out);
			last_word = exp;
			// Leaves the engine time to refill the output queue
			next_cycle();
			if (random_bits(1) != 16'd0)
				next_cycle();
		end
	endtask

	// Level must sit still for 20 quiet cycles before it is compared
	task automatic settle_and_check_level();
		level_t prev;
		int     stable;
		stable = 0;
		prev = level;
		while (stable < 20) begin
			next_cycle();
			stable = (level == prev) ? stable + 1 : 0;
			prev = level;
		end
		check_value("level", written - 2 * words_read, level);
	endtask

	////////////////////
	// Monitor
	////////////////////

	always @(negedge ti_clk) begin
		since_reset = rst ? 0 : ((since_reset < 3) ? since_reset + 1 : since_reset);
		if (since_reset >= 3) begin
			if (!read_prev)
				check_value("data_out", data_prev, data_out);
			if (!write_hist[1])
				assert (level <= level_prev) else begin
					$display("[ERROR] %0t level rose from %h to %h without a write",
						$time, level_prev, level);
					errors++;
				end
			assert (!UUT.deliver || UUT.chunk_room) else begin
				$display("%0t deliver arrived while the output queue was full", $time);
				errors++;
			end
		end
		read_prev = read_en;
		data_prev = data_out;
		write_hist = {write_hist[0], write_en};
		level_prev = level;
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		rst = 1'b1;
		write_en = 1'b0;
		data_in = '0;
		read_en = 1'b0;
		repeat (8) @(posedge ti_clk);
		#1;
		rst = 1'b0;
		check_value("level", 32'd0, level);
		check_value("data_out", 32'd0, data_out);

		// Order and packing
		write_samples(ORDER_SAMPLES);
		settle_and_check_level();
		read_words(ORDER_SAMPLES / 2);
		settle_and_check_level();

		// Empty buffer repeats the last word
		read_words(2);
		settle_and_check_level();

		// Two samples stay behind in the packer
		write_samples(PARTIAL_SAMPLES);
		settle_and_check_level();
		read_words(3);
		settle_and_check_level();

		// Output queue fills and chunks park in the bulk store
		write_samples(BULK_SAMPLES);
		settle_and_check_level();
		read_words(words_ready());
		settle_and_check_level();

		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		repeat (TEST_CYCLES + 2000) @(posedge ti_clk);
		$display("Watchdog expired, the tests did not finish in time");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/stream_fifo_asserts.sv */
`default_nettype none

module stream_fifo_asserts (
	input logic                        ti_clk,
	input logic                        rst,
	input logic                        write_en,
	input logic                        read_en,
	input stream_fifo_pkg::host_word_t data_out,
	input stream_fifo_pkg::level_t     level,
	input logic                        chunk_room,
	input logic                        deliver
);
	timeunit 1ns;
	timeprecision 100ps;

	// Outputs cleared on the cycle after reset
	reset_clears: assert property (@(posedge ti_clk)
		rst |=> (level == '0 && data_out == '0))
		else $error("level or data_out not cleared by reset");

	// Host word holds without a read, empty buffer included
	hold_without_read: assert property (@(posedge ti_clk) disable iff (rst)
		!read_en |=> $stable(data_out))
		else $error("data_out changed without read_en");

	// Level lags the write strobe by one cycle
	level_no_rise: assert property (@(posedge ti_clk) disable iff (rst)
		!$past(write_en) |=> (level <= $past(level)))
		else $error("level rose after a cycle without write_en");

	// Engine only delivers into a free slot
	deliver_has_room: assert property (@(posedge ti_clk) disable iff (rst)
		deliver |-> chunk_room)
		else $error("deliver while the output queue is full");

endmodule

bind stream_fifo stream_fifo_asserts u_asserts (
	.ti_clk    (ti_clk),
	.rst       (rst),
	.write_en  (write_en),
	.read_en   (read_en),
	.data_out  (data_out),
	.level     (level),
	.chunk_room(chunk_room),
	.deliver   (deliver)
);

`default_nettype wire

/* hw/stream_fifo.sv */
`default_nettype none

module stream_fifo #(
	parameter int BULK_ADDR_W = 8,
	parameter int IN_DEPTH_LOG = 3,
	parameter int OUT_DEPTH_LOG = 3
) (
	input  logic                        ti_clk,
	input  logic                        rst,
	input  logic                        write_en,
	input  stream_fifo_pkg::sample_t    data_in,
	input  logic                        read_en,
	output stream_fifo_pkg::host_word_t data_out,
	output stream_fifo_pkg::level_t     level
);
	import stream_fifo_pkg::*;

	logic        chunk_ready;
	chunk_t      chunk_data;
	logic        chunk_take;
	logic        chunk_room;
	logic        deliver;
	chunk_t      deliver_data;
	level_t      in_words;
	chunk_addr_t bulk_chunks;
	level_t      out_words;

	// Input side
	sample_packer #(
		.IN_DEPTH_LOG(IN_DEPTH_LOG)
	) u_sample_packer (
		.ti_clk     (ti_clk),
		.rst        (rst),
		.write_en   (write_en),
		.data_in    (data_in),
		.chunk_take (chunk_take),
		.chunk_ready(chunk_ready),
		.chunk_data (chunk_data),
		.in_words   (in_words)
	);

	// Bulk store and the mover around it
	transfer_engine #(
		.BULK_ADDR_W(BULK_ADDR_W)
	) u_transfer_engine (
		.ti_clk      (ti_clk),
		.rst         (rst),
		.chunk_ready (chunk_ready),
		.chunk_data  (chunk_data),
		.chunk_take  (chunk_take),
		.chunk_room  (chunk_room),
		.deliver     (deliver),
		.deliver_data(deliver_data),
		.bulk_chunks (bulk_chunks)
	);

	// Host side
	word_unpacker #(
		.OUT_DEPTH_LOG(OUT_DEPTH_LOG)
	) u_word_unpacker (
		.ti_clk      (ti_clk),
		.rst         (rst),
		.deliver     (deliver),
		.deliver_data(deliver_data),
		.chunk_room  (chunk_room),
		.read_en     (read_en),
		.data_out    (data_out),
		.out_words   (out_words)
	);

	fill_monitor u_fill_monitor (
		.ti_clk     (ti_clk),
		.rst        (rst),
		.in_words   (in_words),
		.bulk_chunks(bulk_chunks),
		.out_words  (out_words),
		.level      (level)
	);

endmodule

`default_nettype wire

/* hw/fill_monitor.sv */
`default_nettype none

module fill_monitor (
	input  logic                         ti_clk,
	input  logic                         rst,
	input  stream_fifo_pkg::level_t      in_words,
	input  stream_fifo_pkg::chunk_addr_t bulk_chunks,
	input  stream_fifo_pkg::level_t      out_words,
	output stream_fifo_pkg::level_t      level
);
	import stream_fifo_pkg::*;

	// Samples carried by one host word
	localparam int HOST_SAMPLES = HOST_W / SAMPLE_W;

	level_t bulk_words;
	level_t out_samples;
	level_t total;

	////////////////////
	// Weighted sum
	////////////////////

	// Everything scaled to 16-bit words
	assign bulk_words = level_t'(bulk_chunks) * SAMPLES_PER_CHUNK;
	assign out_samples = out_words * HOST_SAMPLES;
	assign total = in_words + bulk_words + out_samples;

	// Wraps together with the bulk store when it laps
	always_ff @(posedge ti_clk) begin
		if (rst)
			level <= '0;
		else
			level <= total;
	end

endmodule

`default_nettype wire

/* hw/word_unpacker.sv */
`default_nettype none

module word_unpacker #(
	parameter int OUT_DEPTH_LOG = 3
) (
	input  logic                        ti_clk,
	input  logic                        rst,
	input  logic                        deliver,
	input  stream_fifo_pkg::chunk_t     deliver_data,
	output logic                        chunk_room,
	input  logic                        read_en,
	output stream_fifo_pkg::host_word_t data_out,
	output stream_fifo_pkg::level_t     out_words
);
	import stream_fifo_pkg::*;

	localparam int DEPTH = 2 ** OUT_DEPTH_LOG;
	localparam int WORDS_PER_CHUNK = CHUNK_W / HOST_W;

	chunk_t                 queue_mem [DEPTH];
	logic [OUT_DEPTH_LOG:0] wr_ptr;
	logic [OUT_DEPTH_LOG:0] rd_ptr;
	logic [OUT_DEPTH_LOG:0] count;
	logic                   half;
	logic                   pop_word;
	chunk_t                 head;

	assign count = wr_ptr - rd_ptr;
	// Top bit of the count is set only when every slot is taken
	assign chunk_room = !count[OUT_DEPTH_LOG];
	assign head = queue_mem[rd_ptr[OUT_DEPTH_LOG-1:0]];

	// Reads on an empty queue leave data_out alone
	assign pop_word = read_en && (count != '0);

	////////////////////
	// Host side
	////////////////////

	// Low half goes out first, the chunk is popped after the high half
	always_ff @(posedge ti_clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			half <= 1'b0;
			data_out <= '0;
		end else begin
			if (deliver)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_word) begin
				data_out <= half ? head[CHUNK_W-1 -: HOST_W] : head[HOST_W-1:0];
				half <= !half;
				if (half)
					rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge ti_clk) begin
		if (deliver)
			queue_mem[wr_ptr[OUT_DEPTH_LOG-1:0]] <= deliver_data;
	end

	// Host words held, minus the low half already read from the head
	assign out_words = level_t'(count) * WORDS_PER_CHUNK - level_t'(half);

endmodule

`default_nettype wire

/* hw/transfer_engine.sv */
`default_nettype none

module transfer_engine #(
	parameter int BULK_ADDR_W = 8
) (
	input  logic                         ti_clk,
	input  logic                         rst,
	input  logic                         chunk_ready,
	input  stream_fifo_pkg::chunk_t      chunk_data,
	output logic                         chunk_take,
	input  logic                         chunk_room,
	output logic                         deliver,
	output stream_fifo_pkg::chunk_t      deliver_data,
	output stream_fifo_pkg::chunk_addr_t bulk_chunks
);
	import stream_fifo_pkg::*;

	engine_state_t          state;
	logic [BULK_ADDR_W-1:0] wr_ptr;
	logic [BULK_ADDR_W-1:0] rd_ptr;
	logic [BULK_ADDR_W-1:0] ptr_diff;
	logic                   in_flight;
	logic                   cmd_wr;
	logic                   cmd_rd;
	chunk_addr_t            cmd_addr;
	chunk_t                 cmd_wdata;
	bulk_cmd_t              bulk_cmd;
	chunk_t                 rd_data;

	////////////////////
	// Engine FSM
	////////////////////

	// Writes win over reads, and only one store access is open at a time
	always_ff @(posedge ti_clk) begin
		if (rst) begin
			state <= ENG_IDLE;
			wr_ptr <= '0;
			rd_ptr <= '0;
			cmd_wr <= 1'b0;
			cmd_rd <= 1'b0;
			chunk_take <= 1'b0;
		end else begin
			case (state)
				ENG_IDLE: begin
					if (chunk_ready) begin
						cmd_wr <= 1'b1;
						chunk_take <= 1'b1;
						state <= ENG_WRITE;
					end else if (bulk_chunks != '0 && chunk_room) begin
						cmd_rd <= 1'b1;
						rd_ptr <= rd_ptr + 1'b1;
						state <= ENG_READ;
					end
				end
				ENG_WRITE: begin
					// Store write and packer pop land on the same edge
					cmd_wr <= 1'b0;
					chunk_take <= 1'b0;
					wr_ptr <= wr_ptr + 1'b1;
					state <= ENG_IDLE;
				end
				ENG_READ: begin
					cmd_rd <= 1'b0;
					state <= ENG_DELIVER;
				end
				ENG_DELIVER: begin
					state <= ENG_IDLE;
				end
				default: begin
					state <= ENG_IDLE;
				end
			endcase
		end
	end

	// Command address and payload, captured when a transfer is chosen
	always_ff @(posedge ti_clk) begin
		if (state == ENG_IDLE) begin
			cmd_addr <= chunk_ready ? chunk_addr_t'(wr_ptr) : chunk_addr_t'(rd_ptr);
			cmd_wdata <= chunk_data;
		end
	end

	assign bulk_cmd.wr = cmd_wr;
	assign bulk_cmd.rd = cmd_rd;
	assign bulk_cmd.addr = cmd_addr;
	assign bulk_cmd.wdata = cmd_wdata;

	bulk_store #(
		.BULK_ADDR_W(BULK_ADDR_W)
	) u_bulk_store (
		.ti_clk  (ti_clk),
		.bulk_cmd(bulk_cmd),
		.rd_data (rd_data)
	);

	assign deliver = (state == ENG_DELIVER);
	assign deliver_data = rd_data;

	////////////////////
	// Occupancy
	////////////////////

	// Difference wraps with the store depth
	assign ptr_diff = wr_ptr - rd_ptr;

	// A chunk being read still counts until the unpacker holds it
	assign in_flight = (state == ENG_READ) || (state == ENG_DELIVER);
	assign bulk_chunks = chunk_addr_t'(ptr_diff) + chunk_addr_t'(in_flight);

endmodule

`default_nettype wire

/* hw/bulk_store.sv */
`default_nettype none

module bulk_store #(
	parameter int BULK_ADDR_W = 8
) (
	input  logic                       ti_clk,
	input  stream_fifo_pkg::bulk_cmd_t bulk_cmd,
	output stream_fifo_pkg::chunk_t    rd_data
);
	import stream_fifo_pkg::*;

	localparam int DEPTH = 2 ** BULK_ADDR_W;

	////////////////////
	// Chunk memory
	////////////////////

	// Stands in for the external SDRAM
	chunk_t                 mem [DEPTH];
	logic [BULK_ADDR_W-1:0] addr;

	// Upper address bits are beyond the store and ignored
	assign addr = bulk_cmd.addr[BULK_ADDR_W-1:0];

	always_ff @(posedge ti_clk) begin
		if (bulk_cmd.wr)
			mem[addr] <= bulk_cmd.wdata;
	end

	// Registered read port, data valid the cycle after the strobe
	always_ff @(posedge ti_clk) begin
		if (bulk_cmd.rd)
			rd_data <= mem[addr];
	end

endmodule

`default_nettype wire

/* hw/sample_packer.sv */
`default_nettype none

module sample_packer #(
	parameter int IN_DEPTH_LOG = 3
) (
	input  logic                     ti_clk,
	input  logic                     rst,
	input  logic                     write_en,
	input  stream_fifo_pkg::sample_t data_in,
	input  logic                     chunk_take,
	output logic                     chunk_ready,
	output stream_fifo_pkg::chunk_t  chunk_data,
	output stream_fifo_pkg::level_t  in_words
);
	import stream_fifo_pkg::*;

	localparam int DEPTH = 2 ** IN_DEPTH_LOG;
	localparam int LANE_W = $clog2(SAMPLES_PER_CHUNK);
	localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(SAMPLES_PER_CHUNK - 1);

	chunk_t                queue_mem [DEPTH];
	logic [IN_DEPTH_LOG:0] wr_ptr;
	logic [IN_DEPTH_LOG:0] rd_ptr;
	logic [IN_DEPTH_LOG:0] count;
	logic [LANE_W-1:0]     lane;
	chunk_t                asm_reg;
	chunk_t                next_chunk;
	logic                  full;
	logic                  accept;
	logic                  push;

	// Pointers carry one extra bit so full and empty differ
	assign count = wr_ptr - rd_ptr;
	// Count never exceeds DEPTH, so its top bit alone means full
	assign full = count[IN_DEPTH_LOG];

	// Samples arriving while the queue is full are lost
	assign accept = write_en && !full;
	assign push = accept && (lane == LAST_LANE);

	// Current sample dropped into its lane of the assembly word
	always_comb begin
		next_chunk = asm_reg;
		next_chunk[lane*SAMPLE_W +: SAMPLE_W] = data_in;
	end

	always_ff @(posedge ti_clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			lane <= '0;
		end else begin
			if (accept)
				lane <= lane + 1'b1;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (chunk_take)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge ti_clk) begin
		if (accept)
			asm_reg <= next_chunk;
		if (push)
			queue_mem[wr_ptr[IN_DEPTH_LOG-1:0]] <= next_chunk;
	end

	assign chunk_ready = (count != '0);
	assign chunk_data = queue_mem[rd_ptr[IN_DEPTH_LOG-1:0]];

	// Whole chunks plus samples still waiting in the assembly word
	assign in_words = level_t'(count) * SAMPLES_PER_CHUNK + level_t'(lane);

endmodule

`default_nettype wire

/* hw/stream_fifo_pkg.sv */
`default_nettype none

package stream_fifo_pkg;

	////////////////////
	// Data widths
	////////////////////

	localparam int SAMPLE_W = 16;
	localparam int HOST_W = 32;
	localparam int CHUNK_W = 64;
	localparam int CHUNK_ADDR_W = 24;
	localparam int LEVEL_W = 32;

	// Samples gathered into one bulk store chunk
	localparam int SAMPLES_PER_CHUNK = 4;

	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic [HOST_W-1:0] host_word_t;

	// First sample sits in the lowest 16 bits
	typedef logic [CHUNK_W-1:0] chunk_t;

	// Only the low BULK_ADDR_W bits reach the memory
	typedef logic [CHUNK_ADDR_W-1:0] chunk_addr_t;

	// Buffer fill in 16-bit words
	typedef logic [LEVEL_W-1:0] level_t;

	////////////////////
	// Engine to store
	////////////////////

	typedef struct packed {
		logic wr;
		logic rd;
		chunk_addr_t addr;
		chunk_t wdata;
	} bulk_cmd_t;

	typedef enum logic [1:0] {
		ENG_IDLE,
		ENG_WRITE,
		ENG_READ,
		ENG_DELIVER
	} engine_state_t;

endpackage

`default_nettype wire
